/* csr_read_mux.sv */
/*
 * CSR read port.
 * Selects one machine CSR by address, unknown addresses read zero.
 */
`timescale 1ns/1ps
`include "sru_config.svh"

module csr_read_mux (
    input  sru_pkg::csr_addr_t  csr_raddr,
    input  sru_pkg::xlen_t      mstatus,
    input  sru_pkg::xlen_t      mie,
    input  sru_pkg::xlen_t      mip,
    input  sru_pkg::xlen_t      mtvec,
    input  sru_pkg::xlen_t      mscratch,
    input  sru_pkg::xlen_t      mepc,
    input  sru_pkg::xlen_t      mcause,
    input  sru_pkg::xlen_t      mtval,
    output sru_pkg::xlen_t      csr_rdata
);

always_comb begin
    case (csr_raddr)
        `CSR_MSTATUS:  csr_rdata = mstatus;
        `CSR_MIE:      csr_rdata = mie;
        `CSR_MTVEC:    csr_rdata = mtvec;
        `CSR_MSCRATCH: csr_rdata = mscratch;
        `CSR_MEPC:     csr_rdata = mepc;
        `CSR_MCAUSE:   csr_rdata = mcause;
        `CSR_MTVAL:    csr_rdata = mtval;
        `CSR_MIP:      csr_rdata = mip;
        default:       csr_rdata = '0;
    endcase
end

endmodule

/* irq_ctrl.sv */
/*
 * Machine interrupt control.
 * Input synchronizers, mie register, pending and enable logic, fixed priority.
 */
`timescale 1ns/1ps
`include "sru_config.svh"

module irq_ctrl (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  ext_msip,
    input  logic                  ext_mtip,
    input  logic                  ext_meip,
    input  logic                  trap_en,
    input  sru_pkg::priv_t        prv,
    input  logic                  mstatus_mie,
    input  logic                  csr_wr,
    input  sru_pkg::csr_addr_t    csr_waddr,
    input  sru_pkg::xlen_t        csr_wdata,
    output sru_pkg::xlen_t        mie,
    output sru_pkg::xlen_t        mip,
    output logic                  irq_trigger,
    output sru_pkg::cause_code_t  irq_code
);

sru_pkg::irq_vec_t sync_q;
sru_pkg::irq_vec_t pend_q;
sru_pkg::irq_vec_t en_q;
sru_pkg::irq_vec_t active;
logic              allowed;

// two flop synchronizer, the second stage is mip.
always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
        sync_q <= '0;
        pend_q <= '0;
    end else begin
        sync_q <= {ext_meip, ext_mtip, ext_msip};
        pend_q <= sync_q;
    end
end

// only the three machine enables are writable.
always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
        en_q <= '0;
    end else if (csr_wr && csr_waddr == `CSR_MIE) begin
        en_q <= {csr_wdata[`IRQ_MEI_BIT], csr_wdata[`IRQ_MTI_BIT], csr_wdata[`IRQ_MSI_BIT]};
    end
end

always_comb begin
    mie = '0;
    mie[`IRQ_MSI_BIT] = en_q[0];
    mie[`IRQ_MTI_BIT] = en_q[1];
    mie[`IRQ_MEI_BIT] = en_q[2];
    mip = '0;
    mip[`IRQ_MSI_BIT] = pend_q[0];
    mip[`IRQ_MTI_BIT] = pend_q[1];
    mip[`IRQ_MEI_BIT] = pend_q[2];
end

assign active  = en_q & pend_q;
// user mode is always interruptible by machine interrupts.
assign allowed = (prv == sru_pkg::PRV_U) || (prv == sru_pkg::PRV_M && mstatus_mie);

assign irq_trigger = ~trap_en && allowed && (|active);

// external first, then software, then timer.
always_comb begin
    if (active[2]) irq_code = sru_pkg::cause_code_t'(`IRQ_MEI_BIT);
    else if (active[0]) irq_code = sru_pkg::cause_code_t'(`IRQ_MSI_BIT);
    else if (active[1]) irq_code = sru_pkg::cause_code_t'(`IRQ_MTI_BIT);
    else irq_code = '0;
end

endmodule

/* priv_state.sv */
/*
 * Privilege level and mstatus trap stack.
 * Entry pushes MIE and the level, mret pops them, CSR writes set the fields.
 */
`timescale 1ns/1ps
`include "sru_config.svh"

module priv_state (
    input  logic                clk,
    input  logic                rstn,
    input  logic                trap_en,
    input  logic                irq_trigger,
    input  logic                mret,
    input  logic                csr_wr,
    input  sru_pkg::csr_addr_t  csr_waddr,
    input  sru_pkg::xlen_t      csr_wdata,
    output sru_pkg::priv_t      prv,
    output sru_pkg::xlen_t      mstatus,
    output logic                mstatus_mie,
    output logic                eret_en
);

logic           entry;
logic           mie_q;
logic           mpie_q;
sru_pkg::priv_t mpp_q;
sru_pkg::priv_t mpp_wr;

// exceptions and interrupts enter the same way.
assign entry = trap_en | irq_trigger;

// a return is dropped when an exception arrives in the same cycle.
assign eret_en = mret & ~trap_en;

// unsupported levels written to MPP fall back to user.
assign mpp_wr = (csr_wdata[`MSTATUS_MPP_LSB +: 2] == 2'b11) ? sru_pkg::PRV_M
                                                            : sru_pkg::PRV_U;

always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
        prv <= sru_pkg::PRV_M;
    end else if (entry) begin
        prv <= sru_pkg::PRV_M;
    end else if (mret) begin
        prv <= mpp_q;
    end
end

always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
        mie_q  <= 1'b0;
        mpie_q <= 1'b0;
        mpp_q  <= sru_pkg::PRV_U;
    end else if (entry) begin
        mpp_q  <= prv;
        mpie_q <= mie_q;
        mie_q  <= 1'b0;
    end else if (mret) begin
        mpp_q  <= sru_pkg::PRV_U;
        mie_q  <= mpie_q;
        mpie_q <= 1'b1;
    end else if (csr_wr && csr_waddr == `CSR_MSTATUS) begin
        mie_q  <= csr_wdata[`MSTATUS_MIE_BIT];
        mpie_q <= csr_wdata[`MSTATUS_MPIE_BIT];
        mpp_q  <= mpp_wr;
    end
end

// all other mstatus fields read as zero.
always_comb begin
    mstatus = '0;
    mstatus[`MSTATUS_MIE_BIT] = mie_q;
    mstatus[`MSTATUS_MPIE_BIT] = mpie_q;
    mstatus[`MSTATUS_MPP_LSB +: 2] = mpp_q;
end

assign mstatus_mie = mie_q;

endmodule

/* project.f */
+incdir+.
sru_pkg.sv
irq_ctrl.sv
priv_state.sv
trap_csrs.sv
csr_read_mux.sv
sru_top.sv
sru_sva.sv
tb_sru.sv

/* run.sh */
#!/bin/sh
# build and run the trap unit testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert --timescale 1ns/1ps -f project.f --top-module tb_sru -o tb_sru
out=$(./obj_dir/tb_sru)
echo "$out"
if echo "$out" | grep -q "^Testbench passed$"; then
    exit 0
fi
exit 1

/* sru_config.svh */
/*
 * Machine-mode trap unit configuration.
 * Data width, CSR addresses, mstatus field positions and interrupt codes.
 */
`ifndef SRU_CONFIG_SVH
`define SRU_CONFIG_SVH

// register and data word width.
`define SRU_XLEN 32

// machine CSR addresses.
`define CSR_MSTATUS  12'h300
`define CSR_MIE      12'h304
`define CSR_MTVEC    12'h305
`define CSR_MSCRATCH 12'h340
`define CSR_MEPC     12'h341
`define CSR_MCAUSE   12'h342
`define CSR_MTVAL    12'h343
`define CSR_MIP      12'h344

// mstatus fields, MPP is two bits wide.
`define MSTATUS_MIE_BIT  3
`define MSTATUS_MPIE_BIT 7
`define MSTATUS_MPP_LSB  11

// interrupt bits in mie and mip, equal to the interrupt cause codes.
`define IRQ_MSI_BIT 3
`define IRQ_MTI_BIT 7
`define IRQ_MEI_BIT 11

`endif

/* sru_pkg.sv */
/*
 * Shared types of the trap unit.
 * Data word, CSR address, cause code, interrupt vector and privilege level.
 */
`include "sru_config.svh"

package sru_pkg;

    // one register or data word.
    typedef logic [`SRU_XLEN-1:0] xlen_t;

    // CSR address as carried on the read and write ports.
    typedef logic [11:0] csr_addr_t;

    // exception code field of mcause, below the interrupt flag.
    typedef logic [`SRU_XLEN-2:0] cause_code_t;

    // one bit per machine interrupt.
    // bit 0 software, bit 1 timer, bit 2 external.
    typedef logic [2:0] irq_vec_t;

    // privilege levels, supervisor is not implemented.
    typedef enum logic [1:0] {
        PRV_U = 2'd0,
        PRV_M = 2'd3
    } priv_t;

endpackage

/* sru_sva.sv */
/*
 * Concurrent checks on the trap unit top level.
 * Bound into sru_top.
 */
`timescale 1ns/1ps

module sru_sva (
    input logic           clk,
    input logic           rstn,
    input logic           trap_en,
    input logic           irq_trigger,
    input logic           eret_en,
    input sru_pkg::priv_t prv
);

// an exception request blocks both interrupts and returns.
a_trap_exclusive: assert property (@(posedge clk) disable iff (!rstn)
    trap_en |-> !irq_trigger && !eret_en)
    else $error("irq_trigger or eret_en high together with trap_en");

a_entry_priv: assert property (@(posedge clk) disable iff (!rstn)
    (trap_en || irq_trigger) |=> prv == sru_pkg::PRV_M)
    else $error("prv is not machine after a trap entry");

a_legal_priv: assert property (@(posedge clk) disable iff (!rstn)
    prv == sru_pkg::PRV_U || prv == sru_pkg::PRV_M)
    else $error("prv holds an unsupported level");

endmodule

bind sru_top sru_sva u_sru_sva (
    .clk         (clk),
    .rstn        (rstn),
    .trap_en     (trap_en),
    .irq_trigger (irq_trigger),
    .eret_en     (eret_en),
    .prv         (prv)
);

/* sru_top.sv */
/*
 * Machine-mode trap and status unit.
 * Connects interrupt control, privilege state, trap CSRs and the read mux.
 */
`timescale 1ns/1ps

module sru_top (
    input  logic                clk,
    input  logic                rstn,
    input  logic                trap_en,
    input  sru_pkg::xlen_t      trap_cause,
    input  sru_pkg::xlen_t      trap_val,
    input  sru_pkg::xlen_t      trap_epc,
    input  logic                mret,
    input  logic                ext_msip,
    input  logic                ext_mtip,
    input  logic                ext_meip,
    input  logic                csr_wr,
    input  sru_pkg::csr_addr_t  csr_waddr,
    input  sru_pkg::xlen_t      csr_wdata,
    input  sru_pkg::csr_addr_t  csr_raddr,
    output sru_pkg::priv_t      prv,
    output logic                irq_trigger,
    output sru_pkg::xlen_t      cause,
    output sru_pkg::xlen_t      tval,
    output sru_pkg::xlen_t      trap_vec,
    output sru_pkg::xlen_t      ret_epc,
    output logic                eret_en,
    output sru_pkg::xlen_t      csr_rdata
);

sru_pkg::xlen_t       mstatus;
logic                 mstatus_mie;
sru_pkg::xlen_t       mie;
sru_pkg::xlen_t       mip;
sru_pkg::cause_code_t irq_code;
sru_pkg::xlen_t       mtvec;
sru_pkg::xlen_t       mscratch;
sru_pkg::xlen_t       mepc;
sru_pkg::xlen_t       mcause;
sru_pkg::xlen_t       mtval;

irq_ctrl u_irq_ctrl (
    .clk         (clk),
    .rstn        (rstn),
    .ext_msip    (ext_msip),
    .ext_mtip    (ext_mtip),
    .ext_meip    (ext_meip),
    .trap_en     (trap_en),
    .prv         (prv),
    .mstatus_mie (mstatus_mie),
    .csr_wr      (csr_wr),
    .csr_waddr   (csr_waddr),
    .csr_wdata   (csr_wdata),
    .mie         (mie),
    .mip         (mip),
    .irq_trigger (irq_trigger),
    .irq_code    (irq_code)
);

priv_state u_priv_state (
    .clk         (clk),
    .rstn        (rstn),
    .trap_en     (trap_en),
    .irq_trigger (irq_trigger),
    .mret        (mret),
    .csr_wr      (csr_wr),
    .csr_waddr   (csr_waddr),
    .csr_wdata   (csr_wdata),
    .prv         (prv),
    .mstatus     (mstatus),
    .mstatus_mie (mstatus_mie),
    .eret_en     (eret_en)
);

trap_csrs u_trap_csrs (
    .clk         (clk),
    .rstn        (rstn),
    .trap_en     (trap_en),
    .irq_trigger (irq_trigger),
    .irq_code    (irq_code),
    .trap_cause  (trap_cause),
    .trap_val    (trap_val),
    .trap_epc    (trap_epc),
    .csr_wr      (csr_wr),
    .csr_waddr   (csr_waddr),
    .csr_wdata   (csr_wdata),
    .mtvec       (mtvec),
    .mscratch    (mscratch),
    .mepc        (mepc),
    .mcause      (mcause),
    .mtval       (mtval),
    .trap_vec    (trap_vec),
    .cause       (cause),
    .tval        (tval),
    .ret_epc     (ret_epc)
);

csr_read_mux u_csr_read_mux (
    .csr_raddr (csr_raddr),
    .mstatus   (mstatus),
    .mie       (mie),
    .mip       (mip),
    .mtvec     (mtvec),
    .mscratch  (mscratch),
    .mepc      (mepc),
    .mcause    (mcause),
    .mtval     (mtval),
    .csr_rdata (csr_rdata)
);

endmodule

/* tb_sru.sv */
/*
 * Directed testbench for the machine-mode trap unit.
 * CSR readback, exception entry, mret, interrupt priority and masking.
 */
`timescale 1ns/1ps
`include "sru_config.svh"

module tb_sru;

// cycle budgets of reset and the five tests.
localparam int TEST_CYCLES = 10 + 40 + 30 + 30 + 60 + 60;
localparam sru_pkg::xlen_t MIE_MASK = (32'h1 << `IRQ_MSI_BIT) | (32'h1 << `IRQ_MTI_BIT) |
                                      (32'h1 << `IRQ_MEI_BIT);

logic clk = 1'b0;
logic rstn, trap_en, mret, ext_msip, ext_mtip, ext_meip, csr_wr;
sru_pkg::xlen_t trap_cause, trap_val, trap_epc, csr_wdata;
sru_pkg::csr_addr_t csr_waddr, csr_raddr;
sru_pkg::priv_t prv;
logic irq_trigger, eret_en;
sru_pkg::xlen_t cause, tval, trap_vec, ret_epc, csr_rdata;
sru_pkg::xlen_t last_epc;
int err_count = 0;
int check_count = 0;
int test_count = 0;

sru_top dut0 (.*);

always #20 clk = ~clk;

task automatic compare_xlen(input sru_pkg::xlen_t got, input sru_pkg::xlen_t exp,
                            input string what);
    check_count++;
    if (got !== exp) begin
        $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
        err_count++;
    end
endtask

task automatic compare_priv(input sru_pkg::priv_t got, input sru_pkg::priv_t exp,
                            input string what);
    check_count++;
    if (got !== exp) begin
        $display("[ERROR] %0t ns: %s is %s, expected %s", $time, what, got.name(), exp.name());
        err_count++;
    end
endtask

task automatic compare_bit(input logic got, input logic exp, input string what);
    check_count++;
    if (got !== exp) begin
        $display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
        err_count++;
    end
endtask

function automatic sru_pkg::xlen_t mstatus_value(input logic ie, input logic pie,
                                                 input sru_pkg::priv_t pp);
    sru_pkg::xlen_t v = '0;
    v[`MSTATUS_MIE_BIT] = ie;
    v[`MSTATUS_MPIE_BIT] = pie;
    v[`MSTATUS_MPP_LSB +: 2] = pp;
    return v;
endfunction

// value a CSR reads back after a write of d.
function automatic sru_pkg::xlen_t expected_readback(input sru_pkg::csr_addr_t a,
                                                     input sru_pkg::xlen_t d);
    case (a)
        `CSR_MSTATUS: return mstatus_value(d[`MSTATUS_MIE_BIT], d[`MSTATUS_MPIE_BIT],
            (d[`MSTATUS_MPP_LSB +: 2] == 2'b11) ? sru_pkg::PRV_M : sru_pkg::PRV_U);
        `CSR_MIE: return d & MIE_MASK;
        `CSR_MTVEC: return d & ~32'h2;
        `CSR_MEPC: return d & ~32'h1;
        `CSR_MSCRATCH, `CSR_MCAUSE, `CSR_MTVAL: return d;
        default: return '0;
    endcase
endfunction

// called on a falling edge, returns on the falling edge after the write.
task automatic write_csr(input sru_pkg::csr_addr_t a, input sru_pkg::xlen_t d);
    csr_wr = 1'b1;
    csr_waddr = a;
    csr_wdata = d;
    @(negedge clk);
    csr_wr = 1'b0;
endtask

task automatic check_csr(input sru_pkg::csr_addr_t a, input sru_pkg::xlen_t exp,
                         input string what);
    csr_raddr = a;
    #1;
    compare_xlen(csr_rdata, exp, what);
endtask

task automatic do_mret();
    mret = 1'b1;
    #1;
    compare_bit(eret_en, 1'b1, "eret_en");
    @(negedge clk);
    mret = 1'b0;
endtask

task automatic report_test(input string name, input int errs_before);
    test_count++;
    $display("test %s finished with %0d errors", name, err_count - errs_before);
endtask

task automatic test_reset_readback();
    int e0 = err_count;
    sru_pkg::xlen_t d;
    sru_pkg::csr_addr_t addrs [9] = '{`CSR_MSTATUS, `CSR_MIE, `CSR_MTVEC, `CSR_MSCRATCH,
        `CSR_MEPC, `CSR_MCAUSE, `CSR_MTVAL, `CSR_MIP, 12'h7c0};
    compare_priv(prv, sru_pkg::PRV_M, "prv after reset");
    foreach (addrs[i]) begin
        check_csr(addrs[i], '0, $sformatf("csr %h after reset", addrs[i]));
    end
    foreach (addrs[i]) begin
        d = $urandom();
        write_csr(addrs[i], d);
        check_csr(addrs[i], expected_readback(addrs[i], d),
                  $sformatf("csr %h readback", addrs[i]));
    end
    report_test("reset_readback", e0);
endtask

task automatic test_exception_entry();
    int e0 = err_count;
    sru_pkg::xlen_t vec;
    sru_pkg::xlen_t c;
    sru_pkg::xlen_t v;
    write_csr(`CSR_MIE, '0);
    write_csr(`CSR_MSTATUS, '0);
    do_mret();
    compare_priv(prv, sru_pkg::PRV_U, "prv after mret");
    write_csr(`CSR_MSTATUS, mstatus_value(1'b1, 1'b0, sru_pkg::PRV_U));
    vec = $urandom();
    write_csr(`CSR_MTVEC, vec);
    c = $urandom();
    v = $urandom();
    last_epc = $urandom();
    trap_en = 1'b1;
    trap_cause = c;
    trap_val = v;
    trap_epc = last_epc;
    #1;
    compare_xlen(cause, c, "cause");
    compare_xlen(tval, v, "tval");
    compare_xlen(trap_vec, vec & ~32'h3, "trap_vec");
    @(negedge clk);
    trap_en = 1'b0;
    check_csr(`CSR_MEPC, last_epc, "mepc");
    check_csr(`CSR_MCAUSE, c, "mcause");
    check_csr(`CSR_MTVAL, v, "mtval");
    compare_priv(prv, sru_pkg::PRV_M, "prv after exception");
    check_csr(`CSR_MSTATUS, mstatus_value(1'b0, 1'b1, sru_pkg::PRV_U), "mstatus after exception");
    report_test("exception_entry", e0);
endtask

task automatic test_mret();
    int e0 = err_count;
    sru_pkg::xlen_t c;
    // MPP is user and MPIE is set after the exception test.
    mret = 1'b1;
    #1;
    compare_bit(eret_en, 1'b1, "eret_en");
    compare_xlen(ret_epc, last_epc, "ret_epc");
    @(negedge clk);
    mret = 1'b0;
    compare_priv(prv, sru_pkg::PRV_U, "prv after mret");
    check_csr(`CSR_MSTATUS, mstatus_value(1'b1, 1'b1, sru_pkg::PRV_U), "mstatus after mret");
    write_csr(`CSR_MSTATUS, mstatus_value(1'b0, 1'b0, sru_pkg::PRV_M));
    do_mret();
    compare_priv(prv, sru_pkg::PRV_M, "prv after mret to machine");
    check_csr(`CSR_MSTATUS, mstatus_value(1'b0, 1'b1, sru_pkg::PRV_U), "mstatus after mret");
    // an exception in the mret cycle wins.
    c = $urandom();
    mret = 1'b1;
    trap_en = 1'b1;
    trap_cause = c;
    #1;
    compare_bit(eret_en, 1'b0, "eret_en with trap_en");
    compare_xlen(cause, c, "cause with mret");
    @(negedge clk);
    mret = 1'b0;
    trap_en = 1'b0;
    compare_priv(prv, sru_pkg::PRV_M, "prv after mret and trap");
    check_csr(`CSR_MSTATUS, mstatus_value(1'b0, 1'b0, sru_pkg::PRV_M), "mstatus after trap");
    check_csr(`CSR_MCAUSE, c, "mcause after mret and trap");
    report_test("mret", e0);
endtask

task automatic take_irq(input sru_pkg::irq_vec_t lines, input int code,
                        input sru_pkg::xlen_t base);
    int n = 0;
    write_csr(`CSR_MSTATUS, mstatus_value(1'b1, 1'b0, sru_pkg::PRV_M));
    {ext_meip, ext_mtip, ext_msip} = lines;
    while (!irq_trigger && n < 4) begin
        @(negedge clk);
        n++;
    end
    compare_bit(n <= 2, 1'b1, "irq_trigger within two cycles");
    compare_xlen(cause, 32'h8000_0000 | sru_pkg::xlen_t'(code), "interrupt cause");
    compare_xlen(trap_vec, base + sru_pkg::xlen_t'(code * 4), "vectored trap_vec");
    @(negedge clk);
    {ext_meip, ext_mtip, ext_msip} = 3'b000;
    compare_bit(irq_trigger, 1'b0, "irq_trigger after entry");
    check_csr(`CSR_MCAUSE, 32'h8000_0000 | sru_pkg::xlen_t'(code), "mcause");
    check_csr(`CSR_MTVAL, '0, "mtval after interrupt");
    check_csr(`CSR_MSTATUS, mstatus_value(1'b0, 1'b1, sru_pkg::PRV_M), "mstatus after irq");
    repeat (3) @(negedge clk);
endtask

task automatic test_irq_priority();
    int e0 = err_count;
    sru_pkg::xlen_t base;
    base = $urandom() & ~32'h3;
    write_csr(`CSR_MIE, MIE_MASK);
    write_csr(`CSR_MTVEC, base | 32'h1);
    take_irq(3'b111, `IRQ_MEI_BIT, base);
    take_irq(3'b001, `IRQ_MSI_BIT, base);
    take_irq(3'b010, `IRQ_MTI_BIT, base);
    report_test("irq_priority", e0);
endtask

task automatic test_irq_masking();
    int e0 = err_count;
    sru_pkg::xlen_t c;
    write_csr(`CSR_MIE, 32'h1 << `IRQ_MTI_BIT);
    write_csr(`CSR_MSTATUS, '0);
    ext_mtip = 1'b1;
    repeat (3) begin
        @(negedge clk);
        compare_bit(irq_trigger, 1'b0, "irq_trigger with MIE clear");
    end
    do_mret();
    compare_bit(irq_trigger, 1'b1, "irq_trigger in user mode");
    compare_xlen(cause, 32'h8000_0000 | `IRQ_MTI_BIT, "cause in user mode");
    @(negedge clk);
    ext_mtip = 1'b0;
    compare_priv(prv, sru_pkg::PRV_M, "prv after user interrupt");
    repeat (3) @(negedge clk);
    // software line pending while its enable stays clear.
    ext_msip = 1'b1;
    write_csr(`CSR_MSTATUS, '0);
    do_mret();
    repeat (3) begin
        @(negedge clk);
        compare_bit(irq_trigger, 1'b0, "irq_trigger with mie bit clear");
    end
    write_csr(`CSR_MIE, 32'h1 << `IRQ_MSI_BIT);
    c = $urandom();
    trap_en = 1'b1;
    trap_cause = c;
    #1;
    compare_bit(irq_trigger, 1'b0, "irq_trigger with trap_en");
    compare_xlen(cause, c, "cause with interrupt pending");
    @(negedge clk);
    trap_en = 1'b0;
    ext_msip = 1'b0;
    compare_priv(prv, sru_pkg::PRV_M, "prv after exception");
    check_csr(`CSR_MCAUSE, c, "mcause over pending interrupt");
    report_test("irq_masking", e0);
endtask

initial begin
    repeat (TEST_CYCLES * 3 / 2) @(posedge clk);
    $display("run timed out after %0d cycles", TEST_CYCLES * 3 / 2);
    $display("Testbench failed");
    $finish;
end

initial begin
    void'($urandom(41883));
    rstn = 1'b0;
    trap_en = 1'b0;
    trap_cause = '0;
    trap_val = '0;
    trap_epc = '0;
    mret = 1'b0;
    ext_msip = 1'b0;
    ext_mtip = 1'b0;
    ext_meip = 1'b0;
    csr_wr = 1'b0;
    csr_waddr = '0;
    csr_wdata = '0;
    csr_raddr = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
    test_reset_readback();
    test_exception_entry();
    test_mret();
    test_irq_priority();
    test_irq_masking();
    $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
    if (err_count == 0) begin
        $display("Testbench passed");
    end else begin
        $display("Testbench failed");
    end
    $finish;
end

endmodule

/* trap_csrs.sv */
/*
 * Machine trap CSRs.
 * mtvec, mscratch, mepc, mcause and mtval with trap capture.
 * Drives the trap vector, cause, tval and return address to the core.
 */
`timescale 1ns/1ps
`include "sru_config.svh"

module trap_csrs (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  trap_en,
    input  logic                  irq_trigger,
    input  sru_pkg::cause_code_t  irq_code,
    input  sru_pkg::xlen_t        trap_cause,
    input  sru_pkg::xlen_t        trap_val,
    input  sru_pkg::xlen_t        trap_epc,
    input  logic                  csr_wr,
    input  sru_pkg::csr_addr_t    csr_waddr,
    input  sru_pkg::xlen_t        csr_wdata,
    output sru_pkg::xlen_t        mtvec,
    output sru_pkg::xlen_t        mscratch,
    output sru_pkg::xlen_t        mepc,
    output sru_pkg::xlen_t        mcause,
    output sru_pkg::xlen_t        mtval,
    output sru_pkg::xlen_t        trap_vec,
    output sru_pkg::xlen_t        cause,
    output sru_pkg::xlen_t        tval,
    output sru_pkg::xlen_t        ret_epc
);

logic           entry;
sru_pkg::xlen_t irq_cause;
sru_pkg::xlen_t vec_offset;

assign entry     = trap_en | irq_trigger;
assign irq_cause = {1'b1, irq_code};

// interrupt cause and a zero tval when an interrupt is taken.
assign cause = irq_trigger ? irq_cause : trap_cause;
assign tval  = irq_trigger ? '0 : trap_val;

// vectored mode adds four bytes per cause code, interrupts only.
assign vec_offset = (irq_trigger && mtvec[0]) ? (sru_pkg::xlen_t'(irq_code) << 2) : '0;
assign trap_vec   = {mtvec[`SRU_XLEN-1:2], 2'b00} + vec_offset;

assign ret_epc = mepc;

always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
        mtvec <= '0;
    end else if (csr_wr && csr_waddr == `CSR_MTVEC) begin
        // mode 2 and 3 are reserved, keep bit 1 clear.
        mtvec <= csr_wdata & ~sru_pkg::xlen_t'(2);
    end
end

always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
        mscratch <= '0;
    end else if (csr_wr && csr_waddr == `CSR_MSCRATCH) begin
        mscratch <= csr_wdata;
    end
end

// trap capture wins over a CSR write in the same cycle.
always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
        mepc <= '0;
    end else if (entry) begin
        mepc <= trap_epc;
    end else if (csr_wr && csr_waddr == `CSR_MEPC) begin
        mepc <= csr_wdata & ~sru_pkg::xlen_t'(1);
    end
end

always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
        mcause <= '0;
    end else if (entry) begin
        mcause <= cause;
    end else if (csr_wr && csr_waddr == `CSR_MCAUSE) begin
        mcause <= csr_wdata;
    end
end

always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
        mtval <= '0;
    end else if (entry) begin
        mtval <= tval;
    end else if (csr_wr && csr_waddr == `CSR_MTVAL) begin
        mtval <= csr_wdata;
    end
end

endmodule
